// ==== biu/biu_issue.sv ====
// ****************************************
// BIU issue stage
// Drives AW/W or AR for one buffered
// request, then waits for its response
// ****************************************

module biu_issue
  import core_axi_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              buf_valid_i,
  output logic              buf_ready_o,
  input  mem_op_e           buf_op_i,
  input  logic [ADDR_W-1:0] buf_addr_i,
  input  logic [DATA_W-1:0] buf_wdata_i,
  input  logic [STRB_W-1:0] buf_strb_i,
  output logic              aw_valid_o,
  input  logic              aw_ready_i,
  output logic [ADDR_W-1:0] aw_addr_o,
  output logic [2:0]        aw_size_o,
  output logic              w_valid_o,
  input  logic              w_ready_i,
  output logic [DATA_W-1:0] w_data_o,
  output logic [STRB_W-1:0] w_strb_o,
  output logic              w_last_o,
  output logic              ar_valid_o,
  input  logic              ar_ready_i,
  output logic [ADDR_W-1:0] ar_addr_o,
  output logic [2:0]        ar_size_o,
  output logic              pend_valid_o,
  output mem_op_e           pend_op_o,
  input  logic              resp_done_i
);

  issue_state_e      state_q, state_d;
  mem_op_e           op_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [STRB_W-1:0] strb_q;
  logic              aw_done_q, w_done_q;
  logic              take, in_addr, is_store;
  logic              aw_fire, w_fire, ar_fire, addr_end;

  assign buf_ready_o = (state_q == ISS_IDLE);
  assign take        = buf_valid_i && buf_ready_o;
  assign in_addr     = (state_q == ISS_ADDR);
  assign is_store    = (op_q == OP_STORE);

  // AW and W rise together, each drops on its own handshake
  assign aw_valid_o = in_addr && is_store && !aw_done_q;
  assign w_valid_o  = in_addr && is_store && !w_done_q;
  assign ar_valid_o = in_addr && !is_store;

  assign aw_fire = aw_valid_o && aw_ready_i;
  assign w_fire  = w_valid_o && w_ready_i;
  assign ar_fire = ar_valid_o && ar_ready_i;

  assign addr_end = in_addr && (is_store ? ((aw_done_q || aw_fire) && (w_done_q || w_fire))
                                         : ar_fire);

  assign pend_valid_o = addr_end;
  assign pend_op_o    = op_q;

  // Full bus width on every beat
  assign aw_size_o = 3'($clog2(STRB_W));
  assign ar_size_o = 3'($clog2(STRB_W));
  assign aw_addr_o = addr_q;
  assign ar_addr_o = addr_q;
  assign w_data_o  = wdata_q;
  assign w_strb_o  = strb_q;
  assign w_last_o  = 1'b1;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ISS_IDLE: if (take) state_d = ISS_ADDR;
      ISS_ADDR: if (addr_end) state_d = ISS_WAIT;
      ISS_WAIT: if (resp_done_i) state_d = ISS_IDLE;
      default:  state_d = ISS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= ISS_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (take) begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end else begin
        if (aw_fire) aw_done_q <= 1'b1;
        if (w_fire) w_done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      op_q    <= buf_op_i;
      addr_q  <= buf_addr_i;
      wdata_q <= buf_wdata_i;
      strb_q  <= buf_strb_i;
    end
  end

endmodule

// ==== biu/biu_resp.sv ====
// ****************************************
// BIU response stage
// Accepts B or R for the outstanding
// transaction, returns it to the core
// ****************************************

module biu_resp
  import core_axi_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              pend_valid_i,
  input  mem_op_e           pend_op_i,
  input  logic              b_valid_i,
  output logic              b_ready_o,
  input  logic [1:0]        b_resp_i,
  input  logic              r_valid_i,
  output logic              r_ready_o,
  input  logic [DATA_W-1:0] r_data_i,
  input  logic [1:0]        r_resp_i,
  input  logic              r_last_i,
  output logic              resp_done_o,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output mem_op_e           rsp_op_o,
  output logic [DATA_W-1:0] rsp_rdata_o,
  output logic              rsp_err_o
);

  logic              exp_valid_q;
  mem_op_e           exp_op_q;
  logic              rsp_valid_q;
  mem_op_e           rsp_op_q;
  logic [DATA_W-1:0] rsp_rdata_q;
  logic              rsp_err_q;
  logic              b_fire, r_fire;

  // Only the expected channel opens, and only with a free output slot
  assign b_ready_o = exp_valid_q && (exp_op_q == OP_STORE) && !rsp_valid_q;
  assign r_ready_o = exp_valid_q && (exp_op_q == OP_LOAD) && !rsp_valid_q;

  assign b_fire      = b_valid_i && b_ready_o;
  assign r_fire      = r_valid_i && r_ready_o;
  assign resp_done_o = b_fire || r_fire;

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_op_o    = rsp_op_q;
  assign rsp_rdata_o = rsp_rdata_q;
  assign rsp_err_o   = rsp_err_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exp_valid_q <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (pend_valid_i) exp_valid_q <= 1'b1;
      else if (resp_done_o) exp_valid_q <= 1'b0;
      if (resp_done_o) rsp_valid_q <= 1'b1;
      else if (rsp_ready_i) rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pend_valid_i) exp_op_q <= pend_op_i;
    if (b_fire) begin
      rsp_op_q    <= OP_STORE;
      rsp_rdata_q <= '0;
      rsp_err_q   <= (b_resp_i != RESP_OKAY);
    end else if (r_fire) begin
      rsp_op_q    <= OP_LOAD;
      rsp_rdata_q <= r_data_i;
      // Single beat, so a missing last is a protocol error
      rsp_err_q   <= (r_resp_i != RESP_OKAY) || !r_last_i;
    end
  end

endmodule

// ==== common/core_axi_pkg.sv ====
// ****************************************
// Core AXI wrapper package
// Bus widths, opcodes, FSM states and
// machine-level interrupt cause codes
// ****************************************

package core_axi_pkg;

  // Bus geometry
  localparam int ADDR_W = 40;
  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;

  // Interrupt inputs
  localparam int EXT_IRQ_N = 40;
  localparam int CAUSE_W   = 4;

  // Core request opcode
  typedef enum logic {
    OP_LOAD,
    OP_STORE
  } mem_op_e;

  // Issue stage FSM
  typedef enum logic [1:0] {
    ISS_IDLE,
    ISS_ADDR,
    ISS_WAIT
  } issue_state_e;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Machine-level cause codes from the privileged spec
  localparam logic [CAUSE_W-1:0] IRQ_MSI = 4'd3;
  localparam logic [CAUSE_W-1:0] IRQ_MTI = 4'd7;
  localparam logic [CAUSE_W-1:0] IRQ_SEI = 4'd9;
  localparam logic [CAUSE_W-1:0] IRQ_MEI = 4'd11;

endpackage

// ==== design/core_axi_wrap.sv ====
// ****************************************
// Core AXI wrapper top
// Core request/response port to a
// single-beat AXI4 master, plus interrupts
// ****************************************

module core_axi_wrap
  import core_axi_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Core request
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  mem_op_e              req_op_i,
  input  logic [ADDR_W-1:0]    req_addr_i,
  input  logic [DATA_W-1:0]    req_wdata_i,
  input  logic [STRB_W-1:0]    req_strb_i,
  // Core response
  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i,
  output mem_op_e              rsp_op_o,
  output logic [DATA_W-1:0]    rsp_rdata_o,
  output logic                 rsp_err_o,
  // AXI master
  output logic                 aw_valid_o,
  input  logic                 aw_ready_i,
  output logic [ADDR_W-1:0]    aw_addr_o,
  output logic [2:0]           aw_size_o,
  output logic                 w_valid_o,
  input  logic                 w_ready_i,
  output logic [DATA_W-1:0]    w_data_o,
  output logic [STRB_W-1:0]    w_strb_o,
  output logic                 w_last_o,
  input  logic                 b_valid_i,
  output logic                 b_ready_o,
  input  logic [1:0]           b_resp_i,
  output logic                 ar_valid_o,
  input  logic                 ar_ready_i,
  output logic [ADDR_W-1:0]    ar_addr_o,
  output logic [2:0]           ar_size_o,
  input  logic                 r_valid_i,
  output logic                 r_ready_o,
  input  logic [DATA_W-1:0]    r_data_i,
  input  logic [1:0]           r_resp_i,
  input  logic                 r_last_i,
  // Interrupts
  input  logic                 ipi_i,
  input  logic                 time_irq_i,
  input  logic [1:0]           plic_hartx_mint_req_i,
  input  logic [1:0]           plic_hartx_sint_req_i,
  input  logic [EXT_IRQ_N-1:0] ext_int_i,
  output logic                 irq_valid_o,
  output logic [CAUSE_W-1:0]   irq_cause_o,
  output logic [5:0]           irq_ext_id_o
);

  logic              buf_valid, buf_ready;
  mem_op_e           buf_op;
  logic [ADDR_W-1:0] buf_addr;
  logic [DATA_W-1:0] buf_wdata;
  logic [STRB_W-1:0] buf_strb;
  logic              pend_valid;
  mem_op_e           pend_op;
  logic              resp_done;

  req_buffer u_req_buffer (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_op_i    ( req_op_i    ),
    .req_addr_i  ( req_addr_i  ),
    .req_wdata_i ( req_wdata_i ),
    .req_strb_i  ( req_strb_i  ),
    .buf_valid_o ( buf_valid   ),
    .buf_ready_i ( buf_ready   ),
    .buf_op_o    ( buf_op      ),
    .buf_addr_o  ( buf_addr    ),
    .buf_wdata_o ( buf_wdata   ),
    .buf_strb_o  ( buf_strb    )
  );

  biu_issue u_biu_issue (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .buf_valid_i  ( buf_valid  ),
    .buf_ready_o  ( buf_ready  ),
    .buf_op_i     ( buf_op     ),
    .buf_addr_i   ( buf_addr   ),
    .buf_wdata_i  ( buf_wdata  ),
    .buf_strb_i   ( buf_strb   ),
    .aw_valid_o   ( aw_valid_o ),
    .aw_ready_i   ( aw_ready_i ),
    .aw_addr_o    ( aw_addr_o  ),
    .aw_size_o    ( aw_size_o  ),
    .w_valid_o    ( w_valid_o  ),
    .w_ready_i    ( w_ready_i  ),
    .w_data_o     ( w_data_o   ),
    .w_strb_o     ( w_strb_o   ),
    .w_last_o     ( w_last_o   ),
    .ar_valid_o   ( ar_valid_o ),
    .ar_ready_i   ( ar_ready_i ),
    .ar_addr_o    ( ar_addr_o  ),
    .ar_size_o    ( ar_size_o  ),
    .pend_valid_o ( pend_valid ),
    .pend_op_o    ( pend_op    ),
    .resp_done_i  ( resp_done  )
  );

  biu_resp u_biu_resp (
    .clk_i        ( clk_i       ),
    .rst_i        ( rst_i       ),
    .pend_valid_i ( pend_valid  ),
    .pend_op_i    ( pend_op     ),
    .b_valid_i    ( b_valid_i   ),
    .b_ready_o    ( b_ready_o   ),
    .b_resp_i     ( b_resp_i    ),
    .r_valid_i    ( r_valid_i   ),
    .r_ready_o    ( r_ready_o   ),
    .r_data_i     ( r_data_i    ),
    .r_resp_i     ( r_resp_i    ),
    .r_last_i     ( r_last_i    ),
    .resp_done_o  ( resp_done   ),
    .rsp_valid_o  ( rsp_valid_o ),
    .rsp_ready_i  ( rsp_ready_i ),
    .rsp_op_o     ( rsp_op_o    ),
    .rsp_rdata_o  ( rsp_rdata_o ),
    .rsp_err_o    ( rsp_err_o   )
  );

  irq_ctrl u_irq_ctrl (
    .clk_i                 ( clk_i                 ),
    .rst_i                 ( rst_i                 ),
    .ipi_i                 ( ipi_i                 ),
    .time_irq_i            ( time_irq_i            ),
    .plic_hartx_mint_req_i ( plic_hartx_mint_req_i ),
    .plic_hartx_sint_req_i ( plic_hartx_sint_req_i ),
    .ext_int_i             ( ext_int_i             ),
    .irq_valid_o           ( irq_valid_o           ),
    .irq_cause_o           ( irq_cause_o           ),
    .irq_ext_id_o          ( irq_ext_id_o          )
  );

endmodule

// ==== design/irq_ctrl.sv ====
// ****************************************
// Interrupt controller
// Registers the interrupt lines and picks
// the highest-priority machine cause
// ****************************************

module irq_ctrl
  import core_axi_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 ipi_i,
  input  logic                 time_irq_i,
  input  logic [1:0]           plic_hartx_mint_req_i,
  input  logic [1:0]           plic_hartx_sint_req_i,
  input  logic [EXT_IRQ_N-1:0] ext_int_i,
  output logic                 irq_valid_o,
  output logic [CAUSE_W-1:0]   irq_cause_o,
  output logic [5:0]           irq_ext_id_o
);

  logic                 ipi_q, time_q, mint_q, sint_q;
  logic [EXT_IRQ_N-1:0] ext_q;
  logic                 mei;
  logic                 valid_d;
  logic [CAUSE_W-1:0]   cause_d;
  logic [5:0]           ext_id_d;

  assign mei = mint_q || (|ext_q);

  always_comb begin
    valid_d = 1'b1;
    cause_d = '0;
    if (mei) cause_d = IRQ_MEI;
    else if (ipi_q) cause_d = IRQ_MSI;
    else if (time_q) cause_d = IRQ_MTI;
    else if (sint_q) cause_d = IRQ_SEI;
    else valid_d = 1'b0;
  end

  // Lowest set line wins
  always_comb begin
    ext_id_d = '0;
    for (int i = EXT_IRQ_N - 1; i >= 0; i--) begin
      if (ext_q[i]) ext_id_d = 6'(i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ipi_q        <= 1'b0;
      time_q       <= 1'b0;
      mint_q       <= 1'b0;
      sint_q       <= 1'b0;
      ext_q        <= '0;
      irq_valid_o  <= 1'b0;
      irq_cause_o  <= '0;
      irq_ext_id_o <= '0;
    end else begin
      ipi_q  <= ipi_i;
      time_q <= time_irq_i;
      // Hart one's PLIC bits are not used
      mint_q <= plic_hartx_mint_req_i[0];
      sint_q <= plic_hartx_sint_req_i[0];
      ext_q  <= ext_int_i;
      irq_valid_o  <= valid_d;
      irq_cause_o  <= cause_d;
      irq_ext_id_o <= ext_id_d;
    end
  end

endmodule

// ==== design/req_buffer.sv ====
// ****************************************
// Request buffer
// Two-entry FIFO between core requests
// and the AXI issue stage
// ****************************************

module req_buffer
  import core_axi_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  mem_op_e           req_op_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  logic [DATA_W-1:0] req_wdata_i,
  input  logic [STRB_W-1:0] req_strb_i,
  output logic              buf_valid_o,
  input  logic              buf_ready_i,
  output mem_op_e           buf_op_o,
  output logic [ADDR_W-1:0] buf_addr_o,
  output logic [DATA_W-1:0] buf_wdata_o,
  output logic [STRB_W-1:0] buf_strb_o
);

  mem_op_e           op_q    [2];
  logic [ADDR_W-1:0] addr_q  [2];
  logic [DATA_W-1:0] wdata_q [2];
  logic [STRB_W-1:0] strb_q  [2];

  logic       wr_ptr_q, rd_ptr_q;
  logic [1:0] count_q, count_d;
  logic       ready_q;
  logic       push, pop;

  assign push    = req_valid_i && ready_q;
  assign pop     = buf_valid_o && buf_ready_i;
  assign count_d = count_q + 2'(push) - 2'(pop);

  // Ready is registered, so it stays low for the first cycle out of reset
  assign req_ready_o = ready_q;
  assign buf_valid_o = (count_q != 2'd0);

  assign buf_op_o    = op_q[rd_ptr_q];
  assign buf_addr_o  = addr_q[rd_ptr_q];
  assign buf_wdata_o = wdata_q[rd_ptr_q];
  assign buf_strb_o  = strb_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
      ready_q  <= 1'b0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop) rd_ptr_q <= ~rd_ptr_q;
      count_q <= count_d;
      ready_q <= (count_d != 2'd2);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      op_q[wr_ptr_q]    <= req_op_i;
      addr_q[wr_ptr_q]  <= req_addr_i;
      wdata_q[wr_ptr_q] <= req_wdata_i;
      strb_q[wr_ptr_q]  <= req_strb_i;
    end
  end

endmodule

// ==== flist.f ====
common/core_axi_pkg.sv
design/req_buffer.sv
biu/biu_issue.sv
biu/biu_resp.sv
design/irq_ctrl.sv
design/core_axi_wrap.sv
verif/axi_mem_model.sv
verif/tb_core_axi_wrap.sv

// ==== verif/axi_mem_model.sv ====
// ****************************************
// AXI memory slave for the testbench
// Single-beat reads and writes with random
// ready stalls and response delay
// ****************************************

module axi_mem_model
  import core_axi_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  input  logic [ADDR_W-1:0] aw_addr_i,
  input  logic              w_valid_i,
  output logic              w_ready_o,
  input  logic [DATA_W-1:0] w_data_i,
  input  logic [STRB_W-1:0] w_strb_i,
  output logic              b_valid_o,
  input  logic              b_ready_i,
  output logic [1:0]        b_resp_o,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  logic [ADDR_W-1:0] ar_addr_i,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output logic [DATA_W-1:0] r_data_o,
  output logic [1:0]        r_resp_o,
  output logic              r_last_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [DATA_W-1:0] mem [256];
  integer            seed;
  logic              aw_hs, w_hs, ar_hs, b_hs, r_hs;
  logic [ADDR_W-1:0] aw_addr_q, ar_addr_q;
  logic [DATA_W-1:0] w_data_q;
  logic [STRB_W-1:0] w_strb_q;
  logic              have_aw, have_w, b_pend, r_pend;
  int                b_wait, r_wait;

  initial begin
    seed = 69;
    for (int i = 0; i < 256; i++) mem[i] = {8{8'(i)}} ^ 64'h0f1e_2d3c_4b5a_6978;
    {aw_ready_o, w_ready_o, ar_ready_o, b_valid_o, r_valid_o} = '0;
    {aw_hs, w_hs, ar_hs, b_hs, r_hs} = '0;
    b_resp_o = RESP_OKAY;
    r_resp_o = RESP_OKAY;
    r_data_o = '0;
    r_last_o = 1'b1;
  end

  // Handshakes seen on the rising edge, acted on at the falling edge
  always @(posedge clk_i) begin
    aw_hs = aw_valid_i && aw_ready_o;
    w_hs  = w_valid_i && w_ready_o;
    ar_hs = ar_valid_i && ar_ready_o;
    b_hs  = b_valid_o && b_ready_i;
    r_hs  = r_valid_o && r_ready_i;
    if (aw_hs) aw_addr_q = aw_addr_i;
    if (w_hs) begin
      w_data_q = w_data_i;
      w_strb_q = w_strb_i;
    end
    if (ar_hs) ar_addr_q = ar_addr_i;
  end

  always @(negedge clk_i) begin
    if (rst_i) begin
      {aw_ready_o, w_ready_o, ar_ready_o, b_valid_o, r_valid_o} = '0;
      {have_aw, have_w, b_pend, r_pend} = '0;
    end else begin
      if (aw_hs) have_aw = 1'b1;
      if (w_hs) have_w = 1'b1;
      if (b_hs) b_valid_o = 1'b0;
      if (r_hs) r_valid_o = 1'b0;
      if (have_aw && have_w) begin
        // Bit 39 marks the error region, which is never written
        if (!aw_addr_q[ADDR_W-1]) begin
          for (int k = 0; k < STRB_W; k++) begin
            if (w_strb_q[k]) mem[aw_addr_q[10:3]][8*k +: 8] = w_data_q[8*k +: 8];
          end
        end
        b_resp_o = aw_addr_q[ADDR_W-1] ? RESP_SLVERR : RESP_OKAY;
        b_wait   = $unsigned($random(seed)) % 4;
        b_pend   = 1'b1;
        have_aw  = 1'b0;
        have_w   = 1'b0;
      end
      if (ar_hs) begin
        r_data_o = ar_addr_q[ADDR_W-1] ? '0 : mem[ar_addr_q[10:3]];
        r_resp_o = ar_addr_q[ADDR_W-1] ? RESP_SLVERR : RESP_OKAY;
        r_wait   = $unsigned($random(seed)) % 4;
        r_pend   = 1'b1;
      end
      if (b_pend) begin
        if (b_wait == 0) begin
          b_valid_o = 1'b1;
          b_pend    = 1'b0;
        end else b_wait--;
      end
      if (r_pend) begin
        if (r_wait == 0) begin
          r_valid_o = 1'b1;
          r_pend    = 1'b0;
        end else r_wait--;
      end
      aw_ready_o = ($unsigned($random(seed)) % 4) != 0;
      w_ready_o  = ($unsigned($random(seed)) % 4) != 0;
      ar_ready_o = ($unsigned($random(seed)) % 4) != 0;
    end
  end

endmodule

// ==== verif/tb_core_axi_wrap.sv ====
// ****************************************
// Testbench for the core AXI wrapper
// Random core traffic and interrupt inputs
// checked against a reference model
// ****************************************

module tb_core_axi_wrap
  import core_axi_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_PAIRS   = 8;
  localparam int N_RANDOM  = 300;
  localparam int N_ERR_REQ = 4;
  localparam int N_IRQ     = 100;
  localparam int TOTAL_REQ = 1 + 2 * N_PAIRS + N_RANDOM + N_ERR_REQ;

  logic clk, rst;
  logic req_valid_i, req_ready_o;
  mem_op_e req_op_i;
  logic [ADDR_W-1:0] req_addr_i;
  logic [DATA_W-1:0] req_wdata_i;
  logic [STRB_W-1:0] req_strb_i;
  logic rsp_valid_o, rsp_ready_i, rsp_err_o;
  mem_op_e rsp_op_o;
  logic [DATA_W-1:0] rsp_rdata_o;
  logic aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
  logic ar_valid, ar_ready, r_valid, r_ready, r_last;
  logic [ADDR_W-1:0] aw_addr, ar_addr;
  logic [2:0] aw_size, ar_size;
  logic [DATA_W-1:0] w_data, r_data;
  logic [STRB_W-1:0] w_strb;
  logic [1:0] b_resp, r_resp;
  logic ipi_i, time_irq_i;
  logic [1:0] plic_hartx_mint_req_i, plic_hartx_sint_req_i;
  logic [EXT_IRQ_N-1:0] ext_int_i;
  logic irq_valid_o;
  logic [CAUSE_W-1:0] irq_cause_o;
  logic [5:0] irq_ext_id_o;

  integer seed;
  integer bp_seed;
  int ready_pct;
  int n_req, n_rsp, n_axi, test_errs, total_errs, n_tests, n_failed;
  string cur_test;
  logic [DATA_W-1:0] ref_mem [256];
  mem_op_e exp_op_q [$];
  logic [DATA_W-1:0] exp_data_q [$];
  logic exp_err_q [$];

  core_axi_wrap u_dut (
    .clk_i (clk), .rst_i (rst),
    .req_valid_i, .req_ready_o, .req_op_i, .req_addr_i, .req_wdata_i, .req_strb_i,
    .rsp_valid_o, .rsp_ready_i, .rsp_op_o, .rsp_rdata_o, .rsp_err_o,
    .aw_valid_o (aw_valid), .aw_ready_i (aw_ready), .aw_addr_o (aw_addr),
    .aw_size_o (aw_size), .w_valid_o (w_valid), .w_ready_i (w_ready),
    .w_data_o (w_data), .w_strb_o (w_strb), .w_last_o (w_last),
    .b_valid_i (b_valid), .b_ready_o (b_ready), .b_resp_i (b_resp),
    .ar_valid_o (ar_valid), .ar_ready_i (ar_ready), .ar_addr_o (ar_addr),
    .ar_size_o (ar_size), .r_valid_i (r_valid), .r_ready_o (r_ready),
    .r_data_i (r_data), .r_resp_i (r_resp), .r_last_i (r_last),
    .ipi_i, .time_irq_i, .plic_hartx_mint_req_i, .plic_hartx_sint_req_i, .ext_int_i,
    .irq_valid_o, .irq_cause_o, .irq_ext_id_o
  );

  axi_mem_model u_mem (
    .clk_i (clk), .rst_i (rst),
    .aw_valid_i (aw_valid), .aw_ready_o (aw_ready), .aw_addr_i (aw_addr),
    .w_valid_i (w_valid), .w_ready_o (w_ready), .w_data_i (w_data), .w_strb_i (w_strb),
    .b_valid_o (b_valid), .b_ready_i (b_ready), .b_resp_o (b_resp),
    .ar_valid_i (ar_valid), .ar_ready_o (ar_ready), .ar_addr_i (ar_addr),
    .r_valid_o (r_valid), .r_ready_i (r_ready), .r_data_o (r_data),
    .r_resp_o (r_resp), .r_last_o (r_last)
  );

  always #2 clk = ~clk;

  initial begin
    repeat (200 * TOTAL_REQ + 1000) @(posedge clk);
    $display("Run timed out waiting for responses (%0d of %0d received)", n_rsp, n_req);
    $display("Test failures found");
    $finish;
  end

  task automatic check_val(string what, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
    assert (exp === act) else begin
      $display("ERR %s %s expected %h actual %h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic start_test(string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    n_tests++;
    total_errs += test_errs;
    if (test_errs == 0) $display("test %s: pass", cur_test);
    else begin
      $display("test %s: FAIL with %0d errors", cur_test, test_errs);
      n_failed++;
    end
  endtask

  // Reference memory fill matches the slave
  function automatic logic [DATA_W-1:0] fill_word(int idx);
    return {8{8'(idx)}} ^ 64'h0f1e_2d3c_4b5a_6978;
  endfunction

  function automatic logic [ADDR_W-1:0] make_addr(logic err, logic [7:0] idx);
    return {err, 28'($random(seed)), idx, 3'b000};
  endfunction

  function automatic void predict(mem_op_e op, logic [ADDR_W-1:0] addr,
                                  logic [DATA_W-1:0] wdata, logic [STRB_W-1:0] strb);
    logic err;
    logic [DATA_W-1:0] word;
    err  = addr[ADDR_W-1];
    word = ref_mem[addr[10:3]];
    if (op == OP_STORE) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (strb[b]) word[8*b +: 8] = wdata[8*b +: 8];
      end
      if (!err) ref_mem[addr[10:3]] = word;
      exp_data_q.push_back('0);
    end else begin
      exp_data_q.push_back(err ? '0 : word);
    end
    exp_op_q.push_back(op);
    exp_err_q.push_back(err);
    n_req++;
  endfunction

  // Called on a falling edge; the transfer lands on the next rising edge
  task automatic issue_req(mem_op_e op, logic [ADDR_W-1:0] addr,
                           logic [DATA_W-1:0] wdata, logic [STRB_W-1:0] strb);
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_strb_i  = strb;
    while (!req_ready_o) @(negedge clk);
    predict(op, addr, wdata, strb);
    @(negedge clk);
    req_valid_i = 1'b0;
  endtask

  task automatic wait_all_rsp();
    while (n_rsp != n_req) @(negedge clk);
  endtask

  task automatic check_rsp();
    mem_op_e exp_op;
    logic [DATA_W-1:0] exp_data;
    logic exp_err;
    assert (exp_op_q.size() > 0) else begin
      $display("%s: response arrived with no request outstanding", cur_test);
      test_errs++;
    end
    if (exp_op_q.size() > 0) begin
      exp_op   = exp_op_q.pop_front();
      exp_data = exp_data_q.pop_front();
      exp_err  = exp_err_q.pop_front();
      check_val("rsp_op", 64'(exp_op), 64'(rsp_op_o));
      check_val("rsp_err", 64'(exp_err), 64'(rsp_err_o));
      if (!exp_err || exp_op == OP_STORE) check_val("rsp_rdata", exp_data, rsp_rdata_o);
    end
    n_rsp++;
  endtask

  // Core response side with random back-pressure
  always @(negedge clk) begin
    if (!rst) begin
      rsp_ready_i = ($unsigned($random(bp_seed)) % 100) < ready_pct;
      if (rsp_valid_o && rsp_ready_i) check_rsp();
    end
  end

  // Eight-byte single beats use size code 3 and set last
  always @(negedge clk) begin
    if (!rst) begin
      if (aw_valid) check_val("aw_size", 64'(3), 64'(aw_size));
      if (ar_valid) check_val("ar_size", 64'(3), 64'(ar_size));
      if (w_valid) check_val("w_last", 64'(1), 64'(w_last));
    end
  end

  // Address phases seen on the bus
  always @(posedge clk) begin
    if (!rst && ((aw_valid && aw_ready) || (ar_valid && ar_ready))) n_axi++;
  end

  task automatic irq_test();
    logic [EXT_IRQ_N-1:0] ext;
    logic mei, exp_valid, prev_valid;
    logic [CAUSE_W-1:0] exp_cause, prev_cause;
    logic [5:0] exp_id, prev_id;
    int sel;
    start_test("irq_priority");
    prev_valid = 1'b0;
    prev_cause = '0;
    prev_id    = '0;
    for (int n = 0; n < N_IRQ; n++) begin
      sel = $unsigned($random(seed)) % 4;
      if (sel == 0) ext = '0;
      else if (sel == 1) ext = EXT_IRQ_N'(1) << ($unsigned($random(seed)) % EXT_IRQ_N);
      else ext = EXT_IRQ_N'({$random(seed), $random(seed)});
      ipi_i                 = $random(seed);
      time_irq_i            = $random(seed);
      plic_hartx_mint_req_i = $random(seed);
      plic_hartx_sint_req_i = $random(seed);
      ext_int_i             = ext;
      mei       = plic_hartx_mint_req_i[0] || (|ext);
      exp_valid = mei || ipi_i || time_irq_i || plic_hartx_sint_req_i[0];
      exp_cause = mei ? IRQ_MEI : ipi_i ? IRQ_MSI : time_irq_i ? IRQ_MTI : IRQ_SEI;
      exp_id    = '0;
      for (int i = 0; i < EXT_IRQ_N; i++) begin
        if (ext[i]) begin
          exp_id = 6'(i);
          break;
        end
      end
      // One cycle in, the outputs still reflect the previous inputs
      @(negedge clk);
      check_val("irq_valid early", 64'(prev_valid), 64'(irq_valid_o));
      if (prev_valid) check_val("irq_cause early", 64'(prev_cause), 64'(irq_cause_o));
      check_val("irq_ext_id early", 64'(prev_id), 64'(irq_ext_id_o));
      @(negedge clk);
      check_val("irq_valid", 64'(exp_valid), 64'(irq_valid_o));
      if (exp_valid) check_val("irq_cause", 64'(exp_cause), 64'(irq_cause_o));
      check_val("irq_ext_id", 64'(exp_id), 64'(irq_ext_id_o));
      prev_valid = exp_valid;
      prev_cause = exp_cause;
      prev_id    = exp_id;
    end
    {ipi_i, time_irq_i, plic_hartx_mint_req_i, plic_hartx_sint_req_i, ext_int_i} = '0;
    end_test();
  endtask

  initial begin
    logic [ADDR_W-1:0] addr;
    logic [7:0] idx;
    mem_op_e op;
    seed    = 69;
    bp_seed = seed + 1;
    clk = 1'b0;
    rst = 1'b1;
    ready_pct = 100;
    {n_req, n_rsp, n_axi, test_errs, total_errs, n_tests, n_failed} = '0;
    {req_valid_i, rsp_ready_i, req_addr_i, req_wdata_i, req_strb_i} = '0;
    req_op_i = OP_LOAD;
    {ipi_i, time_irq_i, plic_hartx_mint_req_i, plic_hartx_sint_req_i, ext_int_i} = '0;
    for (int i = 0; i < 256; i++) ref_mem[i] = fill_word(i);
    repeat (3) @(negedge clk);
    rst = 1'b0;

    start_test("reset_state");
    check_val("req_ready", 64'(0), 64'(req_ready_o));
    check_val("axi valids", 64'(0), 64'({aw_valid, w_valid, ar_valid}));
    check_val("bus readies", 64'(0), 64'({b_ready, r_ready}));
    check_val("rsp_valid", 64'(0), 64'(rsp_valid_o));
    check_val("irq_valid", 64'(0), 64'(irq_valid_o));
    issue_req(OP_LOAD, make_addr(1'b0, 8'h11), '0, '0);
    wait_all_rsp();
    end_test();

    start_test("store_load");
    for (int n = 0; n < N_PAIRS; n++) begin
      addr = make_addr(1'b0, 8'($random(seed)));
      issue_req(OP_STORE, addr, {$random(seed), $random(seed)}, 8'($random(seed)));
      issue_req(OP_LOAD, addr, '0, '0);
    end
    wait_all_rsp();
    end_test();

    start_test("random_mix");
    ready_pct = 60;
    for (int n = 0; n < N_RANDOM; n++) begin
      op  = ($random(seed) & 1) ? OP_STORE : OP_LOAD;
      idx = 8'($unsigned($random(seed)) % 64);
      addr = make_addr(($unsigned($random(seed)) % 16) == 0, idx);
      issue_req(op, addr, {$random(seed), $random(seed)}, 8'($random(seed)));
      if (($unsigned($random(seed)) % 4) == 0) @(negedge clk);
    end
    wait_all_rsp();
    repeat (20) @(negedge clk);
    check_val("axi transactions", 64'(n_req), 64'(n_axi));
    check_val("response count", 64'(n_req), 64'(n_rsp));
    ready_pct = 100;
    end_test();

    start_test("error_path");
    issue_req(OP_STORE, make_addr(1'b1, 8'h40), {$random(seed), $random(seed)}, 8'hff);
    issue_req(OP_LOAD, make_addr(1'b0, 8'h40), '0, '0);
    issue_req(OP_LOAD, make_addr(1'b1, 8'h40), '0, '0);
    issue_req(OP_STORE, make_addr(1'b1, 8'h41), {$random(seed), $random(seed)}, 8'h0f);
    wait_all_rsp();
    end_test();

    irq_test();

    $display("%0d tests run, %0d failed, %0d check errors", n_tests, n_failed, total_errs);
    if (n_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
